//--- riscvPkg.sv
package riscvPkg;

    parameter int XLEN = 32; // one word

    typedef logic [XLEN-1:0] wordT; // pc, data, immediates

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011, // r-type alu
        OpImm    = 7'b0010011, // i-type alu
        OpLoad   = 7'b0000011, // lw
        OpStore  = 7'b0100011, // sw
        OpBranch = 7'b1100011, // beq .. bgeu
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111
    } opcodeE;

    // instruction class from main decoder to alu decoder
    typedef enum logic [2:0] {
        AluR      = 3'b000,
        AluI      = 3'b001,
        AluLoad   = 3'b010,
        AluStore  = 3'b011,
        AluBranch = 3'b100,
        AluJump   = 3'b101, // jal and jalr share this
        AluLui    = 3'b110,
        AluAuipc  = 3'b111
    } aluOpE;

    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluAnd   = 4'd2,
        AluOr    = 4'd3,
        AluXor   = 4'd4,
        AluSll   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluSlt   = 4'd8,
        AluSltu  = 4'd9,
        AluPassB = 4'd10 // lui
    } aluCtrlE;

    typedef enum logic [1:0] {
        ResAlu     = 2'b00,
        ResMem     = 2'b01,
        ResPcPlus4 = 2'b10, // link value
        ResPcImm   = 2'b11  // auipc
    } resultSrcE;

    typedef enum logic [1:0] {
        PcPlus4  = 2'b00,
        PcBranch = 2'b01, // pc + imm
        PcJalr   = 2'b11  // alu result, bit 0 cleared
    } pcSrcE;

    typedef enum logic [2:0] {
        ImmI = 3'd0,
        ImmS = 3'd1,
        ImmB = 3'd2,
        ImmU = 3'd3,
        ImmJ = 3'd4
    } immSrcE;

endpackage

//--- ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit import riscvPkg::*; (
    input  opcodeE    opcode,       // instr[6:0]
    input  logic [2:0] funct3,
    input  logic      ZeroFlag,     // rs1 == rs2
    input  logic      NegativeFlag, // signed rs1 < rs2
    input  logic      UnsignedLess, // unsigned rs1 < rs2

    output pcSrcE     PCSrc,
    output resultSrcE ResultSrc,
    output logic      MemWrite,
    output logic      ALUSrc,       // 1 selects imm as alu b
    output immSrcE    ImmSrc,
    output logic      RegWrite,
    output aluOpE     ALUop         // class for alu decoder
);

    logic takeBranch;

    // branch condition per funct3
    always_comb begin
        case (funct3)
            3'b000:  takeBranch = ZeroFlag;      // beq
            3'b001:  takeBranch = ~ZeroFlag;     // bne
            3'b100:  takeBranch = NegativeFlag;  // blt
            3'b101:  takeBranch = ~NegativeFlag; // bge
            3'b110:  takeBranch = UnsignedLess;  // bltu
            3'b111:  takeBranch = ~UnsignedLess; // bgeu
            default: takeBranch = 1'b0;          // 010, 011 not branches
        endcase
    end

    always_comb begin
        // safe defaults, also used for unknown opcodes
        PCSrc     = PcPlus4;
        ResultSrc = ResAlu;
        MemWrite  = 1'b0;
        ALUSrc    = 1'b0;
        ImmSrc    = ImmI;
        RegWrite  = 1'b0;
        ALUop     = AluR;

        case (opcode)
            OpReg: begin
                RegWrite = 1'b1;
            end
            OpImm: begin
                ALUop    = AluI;
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
            end
            OpLoad: begin
                ALUop     = AluLoad;
                ALUSrc    = 1'b1;      // base + offset
                ResultSrc = ResMem;
                RegWrite  = 1'b1;
            end
            OpStore: begin
                ALUop    = AluStore;
                ALUSrc   = 1'b1;
                ImmSrc   = ImmS;
                MemWrite = 1'b1;
            end
            OpBranch: begin
                ALUop  = AluBranch;    // compare rs1 with rs2
                ImmSrc = ImmB;
                PCSrc  = takeBranch ? PcBranch : PcPlus4;
            end
            OpJal: begin
                ALUop     = AluJump;
                ImmSrc    = ImmJ;
                PCSrc     = PcBranch;  // pc + imm
                ResultSrc = ResPcPlus4;
                RegWrite  = 1'b1;
            end
            OpJalr: begin
                ALUop     = AluJump;   // rs1 + imm gives target
                ALUSrc    = 1'b1;
                PCSrc     = PcJalr;
                ResultSrc = ResPcPlus4;
                RegWrite  = 1'b1;
            end
            OpLui: begin
                ALUop    = AluLui;     // imm passes through alu
                ALUSrc   = 1'b1;
                ImmSrc   = ImmU;
                RegWrite = 1'b1;
            end
            OpAuipc: begin
                ALUop     = AluAuipc;
                ALUSrc    = 1'b1;
                ImmSrc    = ImmU;
                ResultSrc = ResPcImm;  // taken from fetch adder
                RegWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- AluDecoder.sv
`timescale 1ns/1ps

module AluDecoder import riscvPkg::*; (
    input  aluOpE      ALUop,
    input  logic [2:0] funct3,
    input  logic       funct7b5, // instr[30]
    output aluCtrlE    aluCtrl
);

    always_comb begin
        case (ALUop)
            AluR, AluI: begin
                case (funct3)
                    3'b000:  aluCtrl = (ALUop == AluR && funct7b5) ? AluSub : AluAdd;
                    3'b001:  aluCtrl = AluSll;
                    3'b010:  aluCtrl = AluSlt;
                    3'b011:  aluCtrl = AluSltu;
                    3'b100:  aluCtrl = AluXor;
                    3'b101:  aluCtrl = funct7b5 ? AluSra : AluSrl; // both formats
                    3'b110:  aluCtrl = AluOr;
                    default: aluCtrl = AluAnd; // 111
                endcase
            end
            AluBranch: begin
                // eq/ne use sub, the rest compare
                if (!funct3[2])
                    aluCtrl = AluSub;
                else if (funct3[1])
                    aluCtrl = AluSltu;
                else
                    aluCtrl = AluSlt;
            end
            AluLui:  aluCtrl = AluPassB;
            default: aluCtrl = AluAdd;   // load, store, jump, auipc
        endcase
    end

endmodule

//--- Alu.sv
`timescale 1ns/1ps

module Alu import riscvPkg::*; (
    input  wordT    a,
    input  wordT    b,
    input  aluCtrlE aluCtrl,
    output wordT    result,
    output logic    ZeroFlag,
    output logic    NegativeFlag, // signed a < b
    output logic    UnsignedLess  // unsigned a < b
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // flags straight from the operands, no overflow trouble
    assign ZeroFlag     = (a == b);
    assign NegativeFlag = ($signed(a) < $signed(b));
    assign UnsignedLess = (a < b);

    always_comb begin
        case (aluCtrl)
            AluAdd:   result = a + b;
            AluSub:   result = a - b;
            AluAnd:   result = a & b;
            AluOr:    result = a | b;
            AluXor:   result = a ^ b;
            AluSll:   result = a << shamt;
            AluSrl:   result = a >> shamt;
            AluSra:   result = $signed(a) >>> shamt;
            AluSlt:   result = {{(XLEN-1){1'b0}}, NegativeFlag};
            AluSltu:  result = {{(XLEN-1){1'b0}}, UnsignedLess};
            AluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

//--- RegFile.sv
`timescale 1ns/1ps

module RegFile import riscvPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [4:0] addrA,   // rs1
    input  logic [4:0] addrB,   // rs2
    input  logic [4:0] addrW,   // rd
    input  logic       writeEn,
    input  wordT       dataW,
    output wordT       dataA,
    output wordT       dataB
);

    wordT regs [1:31]; // x0 not stored

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && addrW != 5'd0) begin
            regs[addrW] <= dataW; // x0 writes dropped
        end
    end

    // combinational reads, x0 hardwired
    assign dataA = (addrA == 5'd0) ? '0 : regs[addrA];
    assign dataB = (addrB == 5'd0) ? '0 : regs[addrB];

endmodule

//--- ImmGen.sv
`timescale 1ns/1ps

module ImmGen import riscvPkg::*; (
    input  wordT   instr,
    input  immSrcE immSrc,
    output wordT   imm
);

    always_comb begin
        case (immSrc)
            ImmI: imm = {{20{instr[31]}}, instr[31:20]};
            ImmS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 always zero
            ImmB: imm = {{19{instr[31]}}, instr[31], instr[7],
                         instr[30:25], instr[11:8], 1'b0};
            ImmU: imm = {instr[31:12], 12'b0}; // upper 20 bits
            ImmJ: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                         instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- FetchUnit.sv
`timescale 1ns/1ps

module FetchUnit import riscvPkg::*; #(
    parameter wordT ResetAddr = '0
) (
    input  logic  clk,
    input  logic  rstN,
    input  pcSrcE pcSrc,
    input  wordT  imm,
    input  wordT  jalrTarget, // rs1 + imm from alu
    output wordT  pc,
    output wordT  pcPlus4,
    output wordT  pcImm       // branch/jal target, auipc result
);

    wordT pcNext;

    assign pcPlus4 = pc + 32'd4;
    assign pcImm   = pc + imm;

    always_comb begin
        case (pcSrc)
            PcBranch: pcNext = pcImm;
            PcJalr:   pcNext = {jalrTarget[XLEN-1:1], 1'b0}; // lsb cleared
            default:  pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= ResetAddr;
        else
            pc <= pcNext;
    end

endmodule

//--- RiscvCore.sv
`timescale 1ns/1ps

module RiscvCore import riscvPkg::*; #(
    parameter wordT ResetAddr = '0
) (
    input  logic clk,
    input  logic rstN,
    input  wordT instr,     // imem read at pc, same cycle
    input  wordT readData,  // dmem read at dataAddr
    output wordT pc,
    output wordT dataAddr,
    output wordT writeData,
    output logic dataWrite  // store strobe, level
);

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic [4:0] rs1Addr;
    logic [4:0] rs2Addr;
    logic [4:0] rdAddr;

    pcSrcE      pcSrc;
    resultSrcE  resultSrc;
    logic       memWrite;
    logic       aluSrc;
    immSrcE     immSrc;
    logic       regWrite;
    aluOpE      aluOp;
    aluCtrlE    aluCtrl;

    wordT       rs1Data;
    wordT       rs2Data;
    wordT       imm;
    wordT       aluB;
    wordT       aluResult;
    logic       zeroFlag;
    logic       negativeFlag;
    logic       unsignedLess;
    wordT       pcPlus4;
    wordT       pcImm;
    wordT       writeBack;

    // instruction fields
    assign opcode   = opcodeE'(instr[6:0]);
    assign rdAddr   = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1Addr  = instr[19:15];
    assign rs2Addr  = instr[24:20];
    assign funct7b5 = instr[30];

    ControlUnit uControl (
        .opcode(opcode), .funct3(funct3),
        .ZeroFlag(zeroFlag), .NegativeFlag(negativeFlag), .UnsignedLess(unsignedLess),
        .PCSrc(pcSrc), .ResultSrc(resultSrc), .MemWrite(memWrite), .ALUSrc(aluSrc),
        .ImmSrc(immSrc), .RegWrite(regWrite), .ALUop(aluOp)
    );

    AluDecoder uAluDec (.ALUop(aluOp), .funct3(funct3), .funct7b5(funct7b5), .aluCtrl(aluCtrl));

    RegFile uRegs (
        .clk(clk), .rstN(rstN),
        .addrA(rs1Addr), .addrB(rs2Addr), .addrW(rdAddr),
        .writeEn(regWrite), .dataW(writeBack),
        .dataA(rs1Data), .dataB(rs2Data)
    );

    ImmGen uImm (.instr(instr), .immSrc(immSrc), .imm(imm));

    assign aluB = aluSrc ? imm : rs2Data; // b operand select

    Alu uAlu (
        .a(rs1Data), .b(aluB), .aluCtrl(aluCtrl), .result(aluResult),
        .ZeroFlag(zeroFlag), .NegativeFlag(negativeFlag), .UnsignedLess(unsignedLess)
    );

    FetchUnit #(.ResetAddr(ResetAddr)) uFetch (
        .clk(clk), .rstN(rstN), .pcSrc(pcSrc), .imm(imm), .jalrTarget(aluResult),
        .pc(pc), .pcPlus4(pcPlus4), .pcImm(pcImm)
    );

    // write-back select
    always_comb begin
        case (resultSrc)
            ResMem:     writeBack = readData;
            ResPcPlus4: writeBack = pcPlus4;   // link
            ResPcImm:   writeBack = pcImm;     // auipc
            default:    writeBack = aluResult;
        endcase
    end

    assign dataAddr  = aluResult; // base + offset
    assign writeData = rs2Data;
    assign dataWrite = memWrite;

endmodule

//--- RiscvCore_assertions.sv
`timescale 1ns/1ps

module RiscvCore_assertions import riscvPkg::*; (
    input logic clk,
    input logic rstN,
    input wordT pc,
    input wordT instr,
    input logic dataWrite
);

    int assertFails = 0; // read by the testbench at the end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned: %h", pc);
            assertFails++;
        end

    strobeKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dataWrite))
        else begin
            $error("dataWrite is unknown");
            assertFails++;
        end

    // only sw may raise the strobe
    strobeOnStore: assert property (@(posedge clk) disable iff (!rstN)
        dataWrite |-> instr[6:0] == OpStore)
        else begin
            $error("dataWrite high for opcode %b", instr[6:0]);
            assertFails++;
        end

endmodule

bind RiscvCore RiscvCore_assertions uAssertions (
    .clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .dataWrite(dataWrite)
);

//--- tb_RiscvCore.sv
`timescale 1ns/1ps

module tb_RiscvCore import riscvPkg::*; ();

    localparam wordT ResetAddr = 32'h0;
    localparam wordT BaseAddr  = 32'h100; // alu results land here
    localparam int   WaitLimit = 64;      // cycles per wait

    logic clk;
    logic rstN;
    wordT instr;
    wordT readData;
    wordT pc;
    wordT dataAddr;
    wordT writeData;
    logic dataWrite;

    wordT rom [0:255]; // word-indexed instruction rom
    wordT ram [0:255]; // data ram
    wordT expAddr [$];
    wordT expData [$];
    int   progLen;
    int   testErrors;
    int   passCount;
    int   failCount;

    RiscvCore #(.ResetAddr(ResetAddr)) dut (
        .clk(clk), .rstN(rstN), .instr(instr), .readData(readData),
        .pc(pc), .dataAddr(dataAddr), .writeData(writeData), .dataWrite(dataWrite)
    );

    always #20 clk = ~clk; // 40 ns period

    assign instr    = rom[pc[9:2]];       // combinational fetch
    assign readData = ram[dataAddr[9:2]]; // combinational load

    always @(posedge clk) begin
        if (rstN && dataWrite === 1'b1)
            ram[dataAddr[9:2]] <= writeData;
    end

    // instruction encoders
    function automatic wordT encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpReg};
    endfunction

    function automatic wordT encI(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                  logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore}; // sw only
    endfunction

    function automatic wordT encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                  logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
    endfunction

    function automatic wordT encU(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic wordT encJ(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
    endfunction

    function automatic wordT signExt12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // rv32i result by funct3 with alt as the instr[30] variant
    function automatic wordT aluRule(logic [2:0] f3, logic alt, wordT a, wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRule(logic [2:0] f3, wordT a, wordT b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkWord(string what, wordT got, wordT exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkPc(wordT got, wordT exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: pc got %h expected %h", $time, got, exp);
            testErrors++;
        end
    endtask

    // rom fill is a nop carrying its own index
    task automatic clearRom();
        for (int i = 0; i < 256; i++)
            rom[i] = encI(OpImm, 5'd0, 3'd0, 5'd0, 12'(i));
        progLen = 0;
        testErrors = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic emit(wordT w);
        rom[progLen] = w;
        progLen++;
    endtask

    task automatic emitLoad(logic [4:0] rd, wordT v); // lui + addi
        wordT hi;
        hi = (v + 32'h800) >> 12; // undo addi sign extension
        emit(encU(OpLui, rd, hi[19:0]));
        emit(encI(OpImm, rd, 3'd0, rd, v[11:0]));
    endtask

    task automatic expectStore(wordT addr, wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic enterReset();
        @(negedge clk);
        rstN = 1'b0;
    endtask

    task automatic leaveReset(); // two cycles in reset
        @(negedge clk);
        checkPc(pc, ResetAddr);
        @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic waitPc(wordT target);
        int n;
        n = 0;
        while (pc !== target && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (pc !== target) begin
            $display("timeout: pc never reached %h within %0d cycles", target, WaitLimit);
            testErrors++;
        end
    endtask

    // waits for a store, checks it, then moves one cycle on
    task automatic checkStore(wordT addr, wordT data);
        int n;
        n = 0;
        while (dataWrite !== 1'b1 && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (dataWrite !== 1'b1) begin
            $display("timeout: no store to %h seen within %0d cycles", addr, WaitLimit);
            testErrors++;
        end else begin
            checkWord("store address", dataAddr, addr);
            checkWord("store data", writeData, data);
            @(negedge clk);
        end
    endtask

    task automatic runStores();
        while (expAddr.size() > 0) begin
            checkStore(expAddr.pop_front(), expData.pop_front());
        end
    endtask

    task automatic finishTest(string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, testErrors);
        end
    endtask

    task automatic testReset();
        enterReset();
        clearRom();
        leaveReset();
        for (int i = 0; i < 5; i++) begin // pc walks by 4 over nops
            checkPc(pc, ResetAddr + 4 * i);
            @(negedge clk);
        end
        finishTest("reset");
    endtask

    task automatic testAluOps();
        wordT       a;
        wordT       b;
        logic [2:0] f3;
        logic       alt;
        logic [11:0] immI;
        int         k;
        a = $urandom();
        b = $urandom();
        enterReset();
        clearRom();
        emitLoad(5'd1, a);
        emitLoad(5'd2, b);
        emitLoad(5'd5, BaseAddr);
        k = 0;
        for (int i = 0; i < 10; i++) begin // 8 funct3 codes plus sub, sra
            f3  = (i < 8) ? i[2:0] : ((i == 8) ? 3'd0 : 3'd5);
            alt = (i >= 8);
            emit(encR(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3));
            emit(encS(5'd3, 5'd5, 12'(4 * k)));
            expectStore(BaseAddr + 4 * k, aluRule(f3, alt, a, b));
            k++;
        end
        for (int i = 0; i < 9; i++) begin // 8 funct3 codes plus srai
            f3   = (i < 8) ? i[2:0] : 3'd5;
            alt  = (i == 8);
            immI = 12'($urandom());
            if (f3 == 3'd1 || f3 == 3'd5)
                immI = {1'b0, alt, 5'b0, immI[4:0]}; // shamt form
            emit(encI(OpImm, 5'd3, f3, 5'd1, immI));
            emit(encS(5'd3, 5'd5, 12'(4 * k)));
            expectStore(BaseAddr + 4 * k, aluRule(f3, alt, a, signExt12(immI)));
            k++;
        end
        leaveReset();
        runStores();
        finishTest("alu operations");
    endtask

    task automatic testLoadStore();
        wordT rnd;
        rnd = $urandom();
        enterReset();
        clearRom();
        ram[8'h80] = rnd; // word at 0x200
        emit(encI(OpLoad, 5'd1, 3'b010, 5'd0, 12'h200));
        emit(encI(OpImm, 5'd1, 3'd0, 5'd1, 12'd1));
        emit(encS(5'd1, 5'd0, 12'h204));
        emit(encI(OpLoad, 5'd0, 3'b010, 5'd0, 12'h200)); // load into x0
        emit(encS(5'd0, 5'd0, 12'h208));
        emit(encI(OpImm, 5'd0, 3'd0, 5'd0, 12'd7));
        emit(encS(5'd0, 5'd0, 12'h20c));
        expectStore(32'h204, rnd + 1);
        expectStore(32'h208, 32'h0);
        expectStore(32'h20c, 32'h0);
        leaveReset();
        runStores();
        finishTest("load and store");
    endtask

    task automatic testBranches();
        logic [2:0] codes [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        wordT pairA [5] = '{32'd5, 32'd5, 32'hffff_fffd, 32'd4, 32'h8000_0000};
        wordT pairB [5] = '{32'd5, 32'd7, 32'd4, 32'hffff_fffd, 32'h7fff_ffff};
        wordT brAddr;
        logic taken;
        testErrors = 0; // one count over all cases
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                enterReset();
                for (int i = 0; i < 256; i++)
                    rom[i] = encI(OpImm, 5'd0, 3'd0, 5'd0, 12'(i));
                progLen = 0;
                emitLoad(5'd1, pairA[p]);
                emitLoad(5'd2, pairB[p]);
                brAddr = progLen * 4;
                emit(encB(codes[c], 5'd1, 5'd2, 13'd16));
                taken = branchRule(codes[c], pairA[p], pairB[p]);
                leaveReset();
                waitPc(brAddr);
                @(negedge clk);
                checkPc(pc, taken ? brAddr + 16 : brAddr + 4);
            end
        end
        finishTest("branches");
    endtask

    task automatic testJumps();
        enterReset();
        clearRom();
        emit(encJ(5'd1, 21'd12));       // 0x00
        progLen = 3;
        emit(encS(5'd1, 5'd0, 12'h120)); // 0x0c
        emitLoad(5'd6, 32'h40);          // 0x10 and 0x14
        emit(encI(OpJalr, 5'd7, 3'd0, 5'd6, 12'd1)); // 0x18 with odd target
        progLen = 16;
        emit(encS(5'd7, 5'd0, 12'h124)); // 0x40
        leaveReset();
        waitPc(32'h0);
        @(negedge clk);
        checkPc(pc, 32'h0c);
        checkStore(32'h120, 32'h4);
        waitPc(32'h18);
        @(negedge clk);
        checkPc(pc, 32'h40); // bit 0 dropped
        checkStore(32'h124, 32'h1c);
        finishTest("jumps");
    endtask

    task automatic testUpperImm();
        logic [19:0] hiLui;
        logic [19:0] hiAuipc;
        wordT        auipcPc;
        hiLui   = 20'($urandom());
        hiAuipc = 20'($urandom());
        enterReset();
        clearRom();
        emit(encU(OpLui, 5'd1, hiLui));
        emit(encS(5'd1, 5'd0, 12'h130));
        progLen = 10;
        auipcPc = progLen * 4;
        emit(encU(OpAuipc, 5'd2, hiAuipc));
        emit(encS(5'd2, 5'd0, 12'h134));
        expectStore(32'h130, {hiLui, 12'b0});
        expectStore(32'h134, {hiAuipc, 12'b0} + auipcPc);
        leaveReset();
        runStores();
        finishTest("upper immediates");
    endtask

    initial begin
        void'($urandom(32'h3f64));
        clk       = 1'b0;
        rstN      = 1'b0;
        passCount = 0;
        failCount = 0;
        for (int i = 0; i < 256; i++)
            ram[i] = 32'h5a00_0000 ^ (i << 2); // address-tagged fill
        testReset();
        testAluOps();
        testLoadStore();
        testBranches();
        testJumps();
        testUpperImm();
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passCount, failCount, dut.uAssertions.assertFails);
        if (failCount == 0 && dut.uAssertions.assertFails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
riscvPkg.sv
ControlUnit.sv
AluDecoder.sv
Alu.sv
RegFile.sv
ImmGen.sv
FetchUnit.sv
RiscvCore.sv
RiscvCore_assertions.sv
tb_RiscvCore.sv

//--- Bender.yml
package:
  name: riscvcore

sources:
  - riscvPkg.sv
  - ControlUnit.sv
  - AluDecoder.sv
  - Alu.sv
  - RegFile.sv
  - ImmGen.sv
  - FetchUnit.sv
  - RiscvCore.sv
  - target: test
    files:
      - RiscvCore_assertions.sv
      - tb_RiscvCore.sv
